// ==== vlog.f ====
hdl/isa_pkg.sv
hdl/fe_pkg.sv
hdl/fetch_thread.sv
hdl/thread_sched.sv
hdl/bundle_decoder.sv
hdl/front_top.sv
dv/front_checker.sv
dv/front_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --timing --assert --timescale 1ns/100ps
TOP       = front_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/front_tb.sv ====
module front_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;
  import fe_pkg::*;

  localparam int TEST_CYCLES = 1500;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
  localparam int MIN_LAT     = 1;
  localparam int MAX_LAT     = 4;
  localparam int WINDOW      = 200;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   stall;
  logic                   except;
  logic                   except_thread;
  fetch_ip_t              except_ip;
  logic                   bus_en;
  slot_t                  bus_slot;
  bundle_t                bus_data;
  logic                   req_en;
  fetch_ip_t              req_addr;
  slot_t                  req_slot;
  logic                   dec_valid;
  logic                   dec_thread;
  fetch_ip_t              dec_ip;
  dec_instr_t [SLOTS-1:0] dec_slots;

  int                     cycles = 0;
  int                     value_errors = 0;
  int                     other_errors = 0;
  int                     delivered [THREADS];
  int                     last_event [THREADS];
  fetch_ip_t              next_ip [THREADS];
  // request side of the model
  fetch_ip_t              req_ip [THREADS];
  logic                   req_epoch [THREADS];
  logic                   held_valid;
  logic                   held_thread;
  fetch_ip_t              held_ip;
  dec_instr_t [SLOTS-1:0] held_slots;
  // responses waiting in the memory model
  int                     mem_due [$];
  slot_t                  mem_slot [$];
  fetch_ip_t              mem_addr [$];

  front_top front_top_inst (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .except        (except),
    .except_thread (except_thread),
    .except_ip     (except_ip),
    .bus_en        (bus_en),
    .bus_slot      (bus_slot),
    .bus_data      (bus_data),
    .req_en        (req_en),
    .req_addr      (req_addr),
    .req_slot      (req_slot),
    .dec_valid     (dec_valid),
    .dec_thread    (dec_thread),
    .dec_ip        (dec_ip),
    .dec_slots     (dec_slots)
  );

  bind front_top front_checker front_checker_inst (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .except        (except),
    .except_thread (except_thread),
    .bus_en        (bus_en),
    .bus_slot      (bus_slot),
    .req_en        (req_en),
    .req_slot      (req_slot),
    .dec_valid     (dec_valid),
    .dec_thread    (dec_thread),
    .dec_ip        (dec_ip),
    .dec_slots     (dec_slots)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // memory content, mixes every address bit with the slot position
  function automatic instr_t hash_word(input fetch_ip_t addr, input int slot);
    logic [31:0] h;
    h = addr[31:0] ^ {addr[47:32], addr[47:32]} ^ (32'(slot) * 32'h9e37_79b9);
    h = h * 32'h85eb_ca6b;
    h = h ^ (h >> 15);
    h = h * 32'hc2b2_ae35;
    h = h ^ (h >> 13);
    // about one word in sixteen is padding
    if (h[31:28] == 4'h0) begin
      h = 32'h0;
    end
    return h;
  endfunction

  function automatic bundle_t make_bundle(input fetch_ip_t addr);
    bundle_t b;
    for (int i = 0; i < SLOTS; i++) begin
      b[i] = hash_word(addr, i);
    end
    return b;
  endfunction

  // op 31:26, rt 25:20, ra 19:14, rb 13:8, imm 7:0
  function automatic dec_instr_t expect_slot(input instr_t w);
    dec_instr_t d;
    d.valid     = (w != 32'h0);
    d.op        = w[31:26];
    d.rt        = w[25:20];
    d.ra        = w[19:14];
    d.rb        = w[13:8];
    d.imm       = w[7:0];
    d.use_const = w[31];
    return d;
  endfunction

  task automatic check_ip(input string name, input fetch_ip_t got, input fetch_ip_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_slot(input int idx, input dec_instr_t got, input dec_instr_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail dec_slots[%0d]: got %h expected %h", idx, got, exp);
    end
  endtask

  task automatic check_thread(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic drive_inputs();
    int        idx;
    fetch_ip_t new_ip;
    idx    = -1;
    stall  = ($urandom_range(0, 3) == 0);
    except = 1'b0;
    if ($urandom_range(0, 59) == 0) begin
      new_ip        = {16'($urandom()), $urandom()};
      new_ip[3:0]   = 4'h0;
      except        = 1'b1;
      except_thread = 1'($urandom_range(0, 1));
      except_ip     = new_ip;
      next_ip[int'(except_thread)]   = new_ip;
      req_ip[int'(except_thread)]    = new_ip;
      req_epoch[int'(except_thread)] = !req_epoch[int'(except_thread)];
      last_event[0] = cycles;
      last_event[1] = cycles;
    end
    bus_en = 1'b0;
    foreach (mem_due[i]) begin
      if ((idx < 0) && (mem_due[i] <= cycles)) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      bus_en   = 1'b1;
      bus_slot = mem_slot[idx];
      bus_data = make_bundle(mem_addr[idx]);
      mem_due.delete(idx);
      mem_slot.delete(idx);
      mem_addr.delete(idx);
    end
  endtask

  task automatic take_request();
    int t;
    if (req_en) begin
      t = int'(req_slot.thread);
      check_ip("req_addr", req_addr, req_ip[t]);
      check_thread("req_slot.epoch", req_slot.epoch, req_epoch[t]);
      req_ip[t] = req_ip[t] + BUNDLE_BYTES;
      mem_due.push_back(cycles + int'($urandom_range(MIN_LAT, MAX_LAT)));
      mem_slot.push_back(req_slot);
      mem_addr.push_back(req_addr);
    end
  endtask

  task automatic check_outputs();
    int t;
    if (stall) begin
      check_thread("dec_valid", dec_valid, held_valid);
      check_thread("dec_thread", dec_thread, held_thread);
      check_ip("dec_ip", dec_ip, held_ip);
      for (int i = 0; i < SLOTS; i++) begin
        check_slot(i, dec_slots[i], held_slots[i]);
      end
    end else if (dec_valid && $isunknown(dec_thread)) begin
      other_errors++;
      $display("decoded bundle carries an unknown thread number");
    end else if (dec_valid) begin
      t = int'(dec_thread);
      check_ip("dec_ip", dec_ip, next_ip[t]);
      for (int i = 0; i < SLOTS; i++) begin
        check_slot(i, dec_slots[i], expect_slot(hash_word(next_ip[t], i)));
      end
      next_ip[t] = next_ip[t] + BUNDLE_BYTES;
      delivered[t]++;
      last_event[t] = cycles;
    end
    held_valid  = dec_valid;
    held_thread = dec_thread;
    held_ip     = dec_ip;
    held_slots  = dec_slots;
    for (int i = 0; i < THREADS; i++) begin
      if (cycles - last_event[i] > WINDOW) begin
        other_errors++;
        $display("thread %0d delivered no bundle for %0d cycles", i, WINDOW);
        last_event[i] = cycles;
      end
    end
  endtask

  initial begin
    rst           = 1'b1;
    stall         = 1'b0;
    except        = 1'b0;
    except_thread = 1'b0;
    except_ip     = '0;
    bus_en        = 1'b0;
    bus_slot      = '0;
    bus_data      = '0;
    for (int i = 0; i < THREADS; i++) begin
      delivered[i]  = 0;
      last_event[i] = 0;
      next_ip[i]    = INIT_IP;
      req_ip[i]     = INIT_IP;
      req_epoch[i]  = 1'b0;
    end
    void'($urandom(32'h538c7ea3));
    repeat (10) @(negedge clk);
    rst = 1'b0;
    // decoder state right after reset
    held_valid  = dec_valid;
    held_thread = dec_thread;
    held_ip     = dec_ip;
    held_slots  = dec_slots;
    repeat (TEST_CYCLES) begin
      drive_inputs();
      // combinational request settles well before the rising edge
      #5;
      take_request();
      @(negedge clk);
      check_outputs();
    end
    for (int i = 0; i < THREADS; i++) begin
      if (delivered[i] == 0) begin
        other_errors++;
        $display("thread %0d delivered no bundle at all", i);
      end
    end
    $display("errors: %0d value, %0d other; bundles thread 0 %0d, thread 1 %0d",
             value_errors, other_errors, delivered[0], delivered[1]);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/front_checker.sv ====
module front_checker (
  input logic                                   clk,
  input logic                                   rst,
  input logic                                   stall,
  input logic                                   except,
  input logic                                   except_thread,
  input logic                                   bus_en,
  input fe_pkg::slot_t                          bus_slot,
  input logic                                   req_en,
  input fe_pkg::slot_t                          req_slot,
  input logic                                   dec_valid,
  input logic                                   dec_thread,
  input fe_pkg::fetch_ip_t                      dec_ip,
  input isa_pkg::dec_instr_t [fe_pkg::SLOTS-1:0] dec_slots
);
  timeunit 1ns;
  timeprecision 100ps;
  import fe_pkg::*;

  logic [THREADS-1:0]  busy;
  slot_t [THREADS-1:0] issued;

  // tag of the request each thread still waits for
  always_ff @(posedge clk) begin
    for (int t = 0; t < THREADS; t++) begin
      if (rst || (except && (except_thread == 1'(t)))) begin
        busy[t] <= 1'b0;
      end else if (req_en && (req_slot.thread == 1'(t))) begin
        busy[t]   <= 1'b1;
        issued[t] <= req_slot;
      end else if (bus_en && (bus_slot == issued[t])) begin
        busy[t] <= 1'b0;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    rst |-> !req_en)
    else $error("bus request issued during reset");

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    stall |=> $stable(dec_valid) && $stable(dec_thread) && $stable(dec_ip) &&
              $stable(dec_slots))
    else $error("decode outputs changed under stall");

  a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
    req_en |-> !busy[req_slot.thread])
    else $error("bus request issued for a thread already waiting");

endmodule

// ==== hdl/front_top.sv ====
module front_top (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   stall,
  input  logic                                   except,
  input  logic                                   except_thread,
  input  fe_pkg::fetch_ip_t                      except_ip,
  input  logic                                   bus_en,
  input  fe_pkg::slot_t                          bus_slot,
  input  fe_pkg::bundle_t                        bus_data,
  output logic                                   req_en,
  output fe_pkg::fetch_ip_t                      req_addr,
  output fe_pkg::slot_t                          req_slot,
  output logic                                   dec_valid,
  output logic                                   dec_thread,
  output fe_pkg::fetch_ip_t                      dec_ip,
  output isa_pkg::dec_instr_t [fe_pkg::SLOTS-1:0] dec_slots
);
  import fe_pkg::*;

  logic [THREADS-1:0]      thr_req;
  logic [THREADS-1:0]      thr_grant;
  logic [THREADS-1:0]      thr_pop;
  logic [THREADS-1:0]      thr_has;
  fetch_ip_t [THREADS-1:0] thr_addr;
  fetch_ip_t [THREADS-1:0] thr_ip;
  slot_t [THREADS-1:0]     thr_slot;
  bundle_t [THREADS-1:0]   thr_bundle;
  logic                    sel_thread;

  for (genvar t = 0; t < THREADS; t++) begin : gen_thread
    fetch_thread fetch_thread_inst (
      .clk           (clk),
      .rst           (rst),
      .thread_id     (1'(t)),
      .except        (except),
      .except_thread (except_thread),
      .except_ip     (except_ip),
      .bus_en        (bus_en),
      .bus_slot      (bus_slot),
      .bus_data      (bus_data),
      .grant         (thr_grant[t]),
      .pop           (thr_pop[t]),
      .req           (thr_req[t]),
      .req_addr      (thr_addr[t]),
      .req_slot      (thr_slot[t]),
      .has_bundle    (thr_has[t]),
      .head_bundle   (thr_bundle[t]),
      .head_ip       (thr_ip[t])
    );
  end

  thread_sched thread_sched_inst (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .except        (except),
    .except_thread (except_thread),
    .req           (thr_req),
    .req_addr_t    (thr_addr),
    .req_slot_t    (thr_slot),
    .has_bundle    (thr_has),
    .grant         (thr_grant),
    .pop           (thr_pop),
    .sel_thread    (sel_thread),
    .req_en        (req_en),
    .req_addr      (req_addr),
    .req_slot      (req_slot)
  );

  // only the selected thread is ever popped
  bundle_decoder bundle_decoder_inst (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .load       (|thr_pop),
    .sel_thread (sel_thread),
    .bundle     (thr_bundle[sel_thread]),
    .ip         (thr_ip[sel_thread]),
    .dec_valid  (dec_valid),
    .dec_thread (dec_thread),
    .dec_ip     (dec_ip),
    .dec_slots  (dec_slots)
  );

endmodule

// ==== hdl/bundle_decoder.sv ====
module bundle_decoder (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   stall,
  input  logic                                   load,
  input  logic                                   sel_thread,
  input  fe_pkg::bundle_t                        bundle,
  input  fe_pkg::fetch_ip_t                      ip,
  output logic                                   dec_valid,
  output logic                                   dec_thread,
  output fe_pkg::fetch_ip_t                      dec_ip,
  output isa_pkg::dec_instr_t [fe_pkg::SLOTS-1:0] dec_slots
);
  import isa_pkg::*;
  import fe_pkg::*;

  dec_instr_t [SLOTS-1:0] split_slots;

  function automatic dec_instr_t split(input instr_t word);
    dec_instr_t d;
    // all-zero word is padding
    d.valid     = (word != '0);
    d.op        = word[OP_LSB +: OP_WIDTH];
    d.rt        = word[RT_LSB +: REG_WIDTH];
    d.ra        = word[RA_LSB +: REG_WIDTH];
    d.rb        = word[RB_LSB +: REG_WIDTH];
    d.imm       = word[IMM_WIDTH-1:0];
    d.use_const = d.op[CONST_OP_BIT];
    return d;
  endfunction

  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      split_slots[i] = split(bundle[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (!stall) begin
      dec_valid <= load;
    end
  end

  // everything holds under stall
  always_ff @(posedge clk) begin
    if (load && !stall) begin
      dec_thread <= sel_thread;
      dec_ip     <= ip;
      dec_slots  <= split_slots;
    end
  end

endmodule

// ==== hdl/thread_sched.sv ====
module thread_sched (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      stall,
  input  logic                                      except,
  input  logic                                      except_thread,
  input  logic [fe_pkg::THREADS-1:0]                req,
  input  fe_pkg::fetch_ip_t [fe_pkg::THREADS-1:0]   req_addr_t,
  input  fe_pkg::slot_t [fe_pkg::THREADS-1:0]       req_slot_t,
  input  logic [fe_pkg::THREADS-1:0]                has_bundle,
  output logic [fe_pkg::THREADS-1:0]                grant,
  output logic [fe_pkg::THREADS-1:0]                pop,
  output logic                                      sel_thread,
  output logic                                      req_en,
  output fe_pkg::fetch_ip_t                         req_addr,
  output fe_pkg::slot_t                             req_slot
);
  import fe_pkg::*;

  logic bus_thread;
  logic prev_thread;

  // thread 0 wins the bus, thread 1 keeps asking
  assign bus_thread = !req[0];
  assign req_en     = |req;
  assign req_addr   = req_addr_t[bus_thread];
  assign req_slot   = req_slot_t[bus_thread];

  always_comb begin
    grant             = '0;
    grant[bus_thread] = req[bus_thread];
  end

  // go to the only thread with work or to the one not being redirected
  always_comb begin
    if (has_bundle[0] && (!has_bundle[1] || (except && except_thread))) begin
      sel_thread = 1'b0;
    end else if (has_bundle[1] && (!has_bundle[0] || (except && !except_thread))) begin
      sel_thread = 1'b1;
    end else begin
      sel_thread = !prev_thread;
    end
  end

  // a queue being flushed this cycle is not popped
  always_comb begin
    for (int t = 0; t < THREADS; t++) begin
      pop[t] = !stall && (sel_thread == 1'(t)) && has_bundle[t] &&
               !(except && (except_thread == 1'(t)));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_thread <= 1'b0;
    end else if (!stall) begin
      prev_thread <= sel_thread;
    end
  end

endmodule

// ==== hdl/fetch_thread.sv ====
module fetch_thread (
  input  logic              clk,
  input  logic              rst,
  input  logic              thread_id,
  input  logic              except,
  input  logic              except_thread,
  input  fe_pkg::fetch_ip_t except_ip,
  input  logic              bus_en,
  input  fe_pkg::slot_t     bus_slot,
  input  fe_pkg::bundle_t   bus_data,
  input  logic              grant,
  input  logic              pop,
  output logic              req,
  output fe_pkg::fetch_ip_t req_addr,
  output fe_pkg::slot_t     req_slot,
  output logic              has_bundle,
  output fe_pkg::bundle_t   head_bundle,
  output fe_pkg::fetch_ip_t head_ip
);
  import fe_pkg::*;

  fetch_ip_t             ip;
  fetch_ip_t             pend_ip;
  logic                  epoch;
  logic                  outstanding;
  bundle_t               q_bundle [QUEUE_DEPTH];
  fetch_ip_t             q_ip [QUEUE_DEPTH];
  logic [QPTR_WIDTH-1:0] wr_ptr;
  logic [QPTR_WIDTH-1:0] rd_ptr;
  logic [QCNT_WIDTH-1:0] count;
  logic                  redirect;
  logic                  resp_hit;
  logic                  do_push;
  logic                  do_pop;

  assign redirect = except && (except_thread == thread_id);

  // stale epoch or other thread: drop
  assign resp_hit = bus_en && outstanding &&
                    (bus_slot.thread == thread_id) && (bus_slot.epoch == epoch);
  assign do_push  = resp_hit && !redirect;
  assign do_pop   = pop && has_bundle && !redirect;

  // only one bundle in flight, so free room covers it once it lands
  assign req      = !rst && !outstanding && !redirect &&
                    (count < QCNT_WIDTH'(QUEUE_DEPTH));
  assign req_addr = ip;
  assign req_slot = '{thread: thread_id, epoch: epoch};

  assign has_bundle  = (count != '0);
  assign head_bundle = q_bundle[rd_ptr];
  assign head_ip     = q_ip[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      ip          <= INIT_IP;
      epoch       <= 1'b0;
      outstanding <= 1'b0;
    end else if (redirect) begin
      ip          <= except_ip;
      epoch       <= !epoch;
      outstanding <= 1'b0;
    end else if (grant) begin
      ip          <= ip + BUNDLE_BYTES;
      outstanding <= 1'b1;
    end else if (resp_hit) begin
      outstanding <= 1'b0;
    end
  end

  // address of the request in flight
  always_ff @(posedge clk) begin
    if (grant) begin
      pend_ip <= ip;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      q_bundle[wr_ptr] <= bus_data;
      q_ip[wr_ptr]     <= pend_ip;
    end
  end

endmodule

// ==== hdl/fe_pkg.sv ====
package fe_pkg;

  localparam int SLOTS       = 4;
  localparam int IP_WIDTH    = 48;
  localparam int QUEUE_DEPTH = 4;
  localparam int THREADS     = 2;

  // queue pointer and fill count
  localparam int QPTR_WIDTH = $clog2(QUEUE_DEPTH);
  localparam int QCNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

  typedef logic [IP_WIDTH-1:0] fetch_ip_t;

  localparam fetch_ip_t INIT_IP      = 48'h0000_f800_0000;
  localparam fetch_ip_t BUNDLE_BYTES = 48'd16;

  // slot 0 sits in the low word
  typedef isa_pkg::instr_t [SLOTS-1:0] bundle_t;

  // bus tag, echoed back with the response
  typedef struct packed {
    logic thread;
    logic epoch;
  } slot_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  localparam int INSTR_WIDTH = 32;
  localparam int OP_WIDTH    = 6;
  localparam int REG_WIDTH   = 6;
  localparam int IMM_WIDTH   = 8;

  // field positions, opcode at the top, immediate in the low byte
  localparam int OP_LSB = INSTR_WIDTH - OP_WIDTH;
  localparam int RT_LSB = OP_LSB - REG_WIDTH;
  localparam int RA_LSB = RT_LSB - REG_WIDTH;
  localparam int RB_LSB = RA_LSB - REG_WIDTH;

  // bit within the opcode, set when operand b is the immediate
  localparam int CONST_OP_BIT = OP_WIDTH - 1;

  typedef logic [INSTR_WIDTH-1:0] instr_t;

  typedef struct packed {
    logic                 valid;
    logic [OP_WIDTH-1:0]  op;
    logic [REG_WIDTH-1:0] rt;
    logic [REG_WIDTH-1:0] ra;
    logic [REG_WIDTH-1:0] rb;
    logic [IMM_WIDTH-1:0] imm;
    logic                 use_const;
  } dec_instr_t;

endpackage
